// File: include/dcs_defs.svh
`ifndef DCS_DEFS_SVH
`define DCS_DEFS_SVH

// largest parameter count of any supported opcode
`define DCS_MAX_PARAMS 4

// cycles the executor holds cmd ready low after a soft reset
`define DCS_RESET_WAIT 6

// unknown-opcode counter width, saturates at all ones
`define DCS_UNK_CNT_W 8

`endif

// File: verilog/dcs_pkg.sv
`default_nettype none

package dcs_pkg;

    // supported DCS write opcodes
    typedef enum logic [7:0] {
        SOFT_RESET       = 8'h01,
        SLEEP_IN         = 8'h10,
        SLEEP_OUT        = 8'h11,
        DISPLAY_OFF      = 8'h28,
        DISPLAY_ON       = 8'h29,
        SET_COLUMN_ADDR  = 8'h2A,
        SET_PAGE_ADDR    = 8'h2B,
        SET_ADDR_MODE    = 8'h36,
        SET_PIXEL_FORMAT = 8'h3A
    } dcs_opcode_e;

    // parameter word, first received byte in bytes[3]
    typedef union packed {
        logic [3:0][7:0] bytes;
        struct packed {
            logic [15:0] start_addr;
            logic [15:0] end_addr;
        } window;
    } dcs_param_u;

    typedef struct packed {
        logic [15:0] col_start;
        logic [15:0] col_end;
        logic [15:0] page_start;
        logic [15:0] page_end;
        logic [7:0]  pixel_format;
        logic [7:0]  addr_mode;
        logic        display_on;
        logic        sleep_out;
    } dcs_panel_state_s;

    // power-on and soft reset values
    localparam dcs_panel_state_s DCS_STATE_DEFAULT = '{
        col_start:    16'h0000,
        col_end:      16'h013F,
        page_start:   16'h0000,
        page_end:     16'h01DF,
        pixel_format: 8'h66,
        addr_mode:    8'h00,
        display_on:   1'b0,
        sleep_out:    1'b0
    };

endpackage

`default_nettype wire

// File: verilog/dcs_cmd_if.sv
`default_nettype none

// one parsed command, parser to executor
interface dcs_cmd_if ();
    import dcs_pkg::*;

    logic        valid;
    logic        ready;
    dcs_opcode_e opcode;
    dcs_param_u  params;

    modport source (
        output valid,
        output opcode,
        output params,
        input  ready
    );

    modport sink (
        input  valid,
        input  opcode,
        input  params,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/dcs_cmd_parser.sv
`default_nettype none

`include "dcs_defs.svh"

module dcs_cmd_parser (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       byte_valid,
    input  wire  [7:0]                byte_data,
    output logic                      byte_ready,
    output logic [`DCS_UNK_CNT_W-1:0] unk_count,
    dcs_cmd_if.source                 cmd
);
    import dcs_pkg::*;

    localparam int CNT_W = $clog2(`DCS_MAX_PARAMS + 1);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_COLLECT = 2'd1;
    localparam logic [1:0] ST_ISSUE   = 2'd2;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] remain_q;
    dcs_opcode_e      opcode_q;
    dcs_param_u       params_q;
    logic             op_known;
    logic [CNT_W-1:0] op_nparams;
    logic             byte_take;
    logic             opcode_take;

    // command table, fixed by the DCS spec
    always_comb begin
        op_known   = 1'b1;
        op_nparams = '0;
        case (byte_data)
            SOFT_RESET,
            SLEEP_IN,
            SLEEP_OUT,
            DISPLAY_OFF,
            DISPLAY_ON: begin
                op_nparams = '0;
            end
            SET_COLUMN_ADDR,
            SET_PAGE_ADDR: begin
                op_nparams = CNT_W'(`DCS_MAX_PARAMS);
            end
            SET_ADDR_MODE,
            SET_PIXEL_FORMAT: begin
                op_nparams = CNT_W'(1);
            end
            default: begin
                op_known = 1'b0;
            end
        endcase
    end

    // stall the byte stream while a finished command waits
    assign byte_ready  = (state_q != ST_ISSUE);
    assign byte_take   = byte_valid && byte_ready;
    assign opcode_take = byte_take && (state_q == ST_IDLE);

    assign cmd.valid  = (state_q == ST_ISSUE);
    assign cmd.opcode = opcode_q;
    assign cmd.params = params_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            remain_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (opcode_take && op_known) begin
                        if (op_nparams == '0) begin
                            state_q <= ST_ISSUE;
                        end else begin
                            state_q  <= ST_COLLECT;
                            remain_q <= op_nparams;
                        end
                    end
                end
                ST_COLLECT: begin
                    if (byte_take) begin
                        remain_q <= remain_q - 1'b1;
                        if (remain_q == CNT_W'(1)) begin
                            state_q <= ST_ISSUE;
                        end
                    end
                end
                ST_ISSUE: begin
                    if (cmd.ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // opcode latch and parameter shift register
    always_ff @(posedge clk) begin
        if (opcode_take) begin
            opcode_q <= dcs_opcode_e'(byte_data);
            params_q <= '0;
        end else if (byte_take) begin
            // only COLLECT accepts bytes outside IDLE
            params_q.bytes <= {params_q.bytes[2:0], byte_data};
        end
    end

    // dropped opcodes, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unk_count <= '0;
        end else if (opcode_take && !op_known && (unk_count != '1)) begin
            unk_count <= unk_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcs_reg_exec.sv
`default_nettype none

`include "dcs_defs.svh"

module dcs_reg_exec (
    input  wire                       clk,
    input  wire                       rst_n,
    dcs_cmd_if.sink                   cmd,
    output dcs_pkg::dcs_panel_state_s state,
    output logic                      cmd_done
);
    import dcs_pkg::*;

    localparam int WAIT_W = $clog2(`DCS_RESET_WAIT + 1);

    logic              cmd_take;
    logic              pend_valid;
    dcs_opcode_e       pend_opcode;
    dcs_param_u        pend_params;
    logic [WAIT_W-1:0] wait_cnt;

    // refuse commands while the soft reset settles
    assign cmd.ready = (wait_cnt == '0);
    assign cmd_take  = cmd.valid && cmd.ready;

    // accepted command held for one cycle, applied on the next edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= cmd_take;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            pend_opcode <= cmd.opcode;
            pend_params <= cmd.params;
        end
    end

    // settle counter starts at the accept edge of SOFT_RESET
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (cmd_take && (cmd.opcode == SOFT_RESET)) begin
            wait_cnt <= WAIT_W'(`DCS_RESET_WAIT);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // panel control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DCS_STATE_DEFAULT;
        end else if (pend_valid) begin
            case (pend_opcode)
                SOFT_RESET: begin
                    state <= DCS_STATE_DEFAULT;
                end
                SLEEP_IN: begin
                    state.sleep_out <= 1'b0;
                end
                SLEEP_OUT: begin
                    state.sleep_out <= 1'b1;
                end
                DISPLAY_OFF: begin
                    state.display_on <= 1'b0;
                end
                DISPLAY_ON: begin
                    state.display_on <= 1'b1;
                end
                SET_COLUMN_ADDR: begin
                    state.col_start <= pend_params.window.start_addr;
                    state.col_end   <= pend_params.window.end_addr;
                end
                SET_PAGE_ADDR: begin
                    state.page_start <= pend_params.window.start_addr;
                    state.page_end   <= pend_params.window.end_addr;
                end
                // single parameter lands in the last byte
                SET_ADDR_MODE: begin
                    state.addr_mode <= pend_params.bytes[0];
                end
                SET_PIXEL_FORMAT: begin
                    state.pixel_format <= pend_params.bytes[0];
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // pulse lines up with the new state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= pend_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcs_ctrl_top.sv
`default_nettype none

`include "dcs_defs.svh"

module dcs_ctrl_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       byte_valid,
    input  wire  [7:0]                byte_data,
    output logic                      byte_ready,
    output logic [15:0]               col_start,
    output logic [15:0]               col_end,
    output logic [15:0]               page_start,
    output logic [15:0]               page_end,
    output logic [7:0]                pixel_format,
    output logic [7:0]                addr_mode,
    output logic                      display_on,
    output logic                      sleep_out,
    output logic                      cmd_done,
    output logic [`DCS_UNK_CNT_W-1:0] unk_count
);
    import dcs_pkg::*;

    dcs_panel_state_s panel_state;

    dcs_cmd_if cmd_if ();

    dcs_cmd_parser parser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_ready (byte_ready),
        .unk_count  (unk_count),
        .cmd        (cmd_if)
    );

    dcs_reg_exec exec_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd_if),
        .state    (panel_state),
        .cmd_done (cmd_done)
    );

    // state struct out as plain ports
    assign col_start    = panel_state.col_start;
    assign col_end      = panel_state.col_end;
    assign page_start   = panel_state.page_start;
    assign page_end     = panel_state.page_end;
    assign pixel_format = panel_state.pixel_format;
    assign addr_mode    = panel_state.addr_mode;
    assign display_on   = panel_state.display_on;
    assign sleep_out    = panel_state.sleep_out;

endmodule

`default_nettype wire

// File: verif/dcs_ctrl_tb.sv
`default_nettype none

`include "dcs_defs.svh"

module dcs_ctrl_tb;
    import dcs_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_GAP      = 3;
    localparam int DONE_WAIT    = `DCS_RESET_WAIT + 10;

    // how each table entry is sent and checked
    localparam int K_APPLY = 0;
    localparam int K_CHAIN = 1;
    localparam int K_STALL = 2;
    localparam int K_DROP  = 3;

    localparam dcs_panel_state_s RESET_STATE = '{
        col_start:    16'h0000,
        col_end:      16'h013F,
        page_start:   16'h0000,
        page_end:     16'h01DF,
        pixel_format: 8'h66,
        addr_mode:    8'h00,
        display_on:   1'b0,
        sleep_out:    1'b0
    };

    typedef struct {
        logic [7:0]  op;
        int          n;
        logic [31:0] w;
        int          kind;
    } entry_t;

    logic                      clk;
    logic                      rst_n;
    logic                      byte_valid;
    logic [7:0]                byte_data;
    logic                      byte_ready;
    logic [15:0]               col_start;
    logic [15:0]               col_end;
    logic [15:0]               page_start;
    logic [15:0]               page_end;
    logic [7:0]                pixel_format;
    logic [7:0]                addr_mode;
    logic                      display_on;
    logic                      sleep_out;
    logic                      cmd_done;
    logic [`DCS_UNK_CNT_W-1:0] unk_count;

    entry_t                    cmd_table[$];
    dcs_panel_state_s          model_state;
    logic [`DCS_UNK_CNT_W-1:0] exp_unk;
    integer                    seed = 32'h071b_f669;
    int                        cyc = 0;
    int                        cycle_limit = 0;
    int                        accept_cyc = 0;
    int                        last_done_cyc = 0;
    int                        prev_done_cyc = 0;
    int                        reset_done_cyc = 0;
    int                        done_count = 0;
    int                        exp_done = 0;
    int                        stall_cycles = 0;
    int                        value_errs = 0;
    int                        other_errs = 0;

    dcs_ctrl_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_ready   (byte_ready),
        .col_start    (col_start),
        .col_end      (col_end),
        .page_start   (page_start),
        .page_end     (page_end),
        .pixel_format (pixel_format),
        .addr_mode    (addr_mode),
        .display_on   (display_on),
        .sleep_out    (sleep_out),
        .cmd_done     (cmd_done),
        .unk_count    (unk_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cycle_limit > 0 && cyc >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // done pulses sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && cmd_done === 1'b1) begin
            done_count++;
            prev_done_cyc = last_done_cyc;
            last_done_cyc = cyc;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
        value_errs++;
    endtask

    task automatic check_state(input dcs_panel_state_s exp, input dcs_panel_state_s act);
        if (exp.col_start !== act.col_start)
            report_mismatch("col_start", exp.col_start, act.col_start);
        if (exp.col_end !== act.col_end)
            report_mismatch("col_end", exp.col_end, act.col_end);
        if (exp.page_start !== act.page_start)
            report_mismatch("page_start", exp.page_start, act.page_start);
        if (exp.page_end !== act.page_end)
            report_mismatch("page_end", exp.page_end, act.page_end);
        if (exp.pixel_format !== act.pixel_format)
            report_mismatch("pixel_format", exp.pixel_format, act.pixel_format);
        if (exp.addr_mode !== act.addr_mode)
            report_mismatch("addr_mode", exp.addr_mode, act.addr_mode);
        if (exp.display_on !== act.display_on)
            report_mismatch("display_on", exp.display_on, act.display_on);
        if (exp.sleep_out !== act.sleep_out)
            report_mismatch("sleep_out", exp.sleep_out, act.sleep_out);
    endtask

    task automatic check_count(input logic [`DCS_UNK_CNT_W-1:0] exp,
                               input logic [`DCS_UNK_CNT_W-1:0] act);
        if (exp !== act)
            report_mismatch("unk_count", exp, act);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        if (exp != act)
            report_mismatch(name, exp, act);
    endtask

    function automatic dcs_panel_state_s read_state();
        return {col_start, col_end, page_start, page_end,
                pixel_format, addr_mode, display_on, sleep_out};
    endfunction

    // reference decode with the first parameter byte most significant
    function automatic dcs_panel_state_s apply_cmd(input dcs_panel_state_s s,
                                                   input logic [7:0] op,
                                                   input logic [31:0] w);
        dcs_panel_state_s r;
        r = s;
        case (op)
            SOFT_RESET:       r = RESET_STATE;
            SLEEP_IN:         r.sleep_out = 1'b0;
            SLEEP_OUT:        r.sleep_out = 1'b1;
            DISPLAY_OFF:      r.display_on = 1'b0;
            DISPLAY_ON:       r.display_on = 1'b1;
            SET_COLUMN_ADDR: begin
                r.col_start = w[31:16];
                r.col_end   = w[15:0];
            end
            SET_PAGE_ADDR: begin
                r.page_start = w[31:16];
                r.page_end   = w[15:0];
            end
            SET_ADDR_MODE:    r.addr_mode = w[7:0];
            SET_PIXEL_FORMAT: r.pixel_format = w[7:0];
            default:          r = s;
        endcase
        return r;
    endfunction

    task automatic add_entry(input logic [7:0] op, input int n, input logic [31:0] w,
                             input int kind);
        entry_t e;
        e.op   = op;
        e.n    = n;
        e.w    = w;
        e.kind = kind;
        cmd_table.push_back(e);
    endtask

    // byte held stable until byte_ready takes it
    task automatic send_byte(input logic [7:0] b, input bit use_gap);
        int gap;
        gap = use_gap ? ($unsigned($random(seed)) % (MAX_GAP + 1)) : 0;
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        byte_valid = 1'b1;
        byte_data  = b;
        while (!byte_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
            stall_cycles++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        accept_cyc = cyc;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
    endtask

    task automatic wait_done(input int idx);
        int waited;
        waited = 0;
        while (done_count < exp_done && waited < DONE_WAIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (done_count < exp_done) begin
            $display("entry %0d: cmd_done did not arrive within %0d cycles", idx, DONE_WAIT);
            other_errs++;
        end
    endtask

    initial begin
        entry_t e;
        int     n_bytes;
        int     n_soft;
        bit     use_gap;
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = 8'h00;

        add_entry(8'h2A, 4, 32'h0010_00EF, K_APPLY);
        add_entry(8'h2B, 4, 32'h0020_01A0, K_APPLY);
        add_entry(8'h3A, 1, 32'h0000_0055, K_APPLY);
        add_entry(8'h36, 1, 32'h0000_00C8, K_APPLY);
        add_entry(8'h29, 0, 32'h0, K_APPLY);
        add_entry(8'h11, 0, 32'h0, K_APPLY);
        add_entry(8'h55, 0, 32'h0, K_DROP);
        add_entry(8'h28, 0, 32'h0, K_APPLY);
        add_entry(8'hFF, 0, 32'h0, K_DROP);
        add_entry(8'h2A, 4, 32'h1234_5678, K_APPLY);
        add_entry(8'h10, 0, 32'h0, K_APPLY);
        add_entry(8'h11, 0, 32'h0, K_APPLY);
        // commands sent straight into the settle wait after a soft reset
        add_entry(8'h01, 0, 32'h0, K_APPLY);
        add_entry(8'h29, 0, 32'h0, K_CHAIN);
        add_entry(8'h3A, 1, 32'h0000_0077, K_STALL);
        add_entry(8'h2B, 4, 32'h0005_0100, K_APPLY);
        add_entry(8'h01, 0, 32'h0, K_APPLY);
        add_entry(8'h36, 1, 32'h0000_00A0, K_CHAIN);
        add_entry(8'h2A, 4, 32'h0001_0002, K_STALL);
        add_entry(8'h55, 0, 32'h0, K_DROP);

        n_bytes = 0;
        n_soft  = 0;
        foreach (cmd_table[i]) begin
            n_bytes += cmd_table[i].n + 1;
            if (cmd_table[i].op == SOFT_RESET)
                n_soft++;
        end
        cycle_limit = RESET_CYCLES + n_bytes * (MAX_GAP + 1) + n_soft * `DCS_RESET_WAIT
                      + cmd_table.size() * 8 + 100;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        model_state = RESET_STATE;
        exp_unk     = '0;
        check_state(model_state, read_state());
        check_count(exp_unk, unk_count);
        check_flag("byte_ready", 1'b1, byte_ready);
        check_flag("cmd_done", 1'b0, cmd_done);

        foreach (cmd_table[i]) begin
            e            = cmd_table[i];
            stall_cycles = 0;
            use_gap      = (e.kind == K_APPLY || e.kind == K_DROP);
            send_byte(e.op, use_gap);
            for (int j = 0; j < e.n; j++) begin
                send_byte(e.w[8 * (e.n - 1 - j) +: 8], use_gap);
            end
            if (e.kind == K_DROP) begin
                if (exp_unk != '1)
                    exp_unk = exp_unk + 1'b1;
                repeat (3) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end else begin
                model_state = apply_cmd(model_state, e.op, e.w);
                exp_done++;
                if (e.kind != K_CHAIN)
                    wait_done(i);
                if (e.kind == K_APPLY) begin
                    check_int("cmd_done latency", 2, last_done_cyc - accept_cyc);
                    if (e.op == SOFT_RESET)
                        reset_done_cyc = last_done_cyc;
                end
                if (e.kind == K_STALL) begin
                    // chained command lands right as the settle wait ends
                    check_int("reset wait release", `DCS_RESET_WAIT + 1,
                              prev_done_cyc - reset_done_cyc);
                    if (stall_cycles == 0) begin
                        $display("entry %0d: byte_ready never dropped for a pending command", i);
                        other_errs++;
                    end
                end
            end
            if (e.kind != K_CHAIN) begin
                check_int("cmd_done pulses", exp_done, done_count);
                check_state(model_state, read_state());
                check_count(exp_unk, unk_count);
            end
        end

        repeat (4) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_int("cmd_done pulses", exp_done, done_count);

        $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
verilog/dcs_pkg.sv
verilog/dcs_cmd_if.sv
verilog/dcs_cmd_parser.sv
verilog/dcs_reg_exec.sv
verilog/dcs_ctrl_top.sv
verif/dcs_ctrl_tb.sv

// File: Bender.yml
package:
  name: dcs_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/dcs_pkg.sv
      - verilog/dcs_cmd_if.sv
      - verilog/dcs_cmd_parser.sv
      - verilog/dcs_reg_exec.sv
      - verilog/dcs_ctrl_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/dcs_ctrl_tb.sv
